// File: list.f
+incdir+include
verilog/redmule_pkg.sv
verilog/redmule_stream_fifo.sv
verilog/redmule_scheduler.sv
verilog/redmule_ctrl_dmr.sv
verilog/redmule_engine.sv
verilog/redmule_top.sv
tb/redmule_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failures
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module redmule_tb \
  --Mdir obj_dir

# The log decides the verdict, so a failing run must not stop the script here
./obj_dir/Vredmule_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"

// File: include/redmule_tb_util.svh
// Testbench helpers, include inside the testbench module body.
// The model accumulates one beat at a time, start it from the bias vector.
// Compare tasks stop the run with $fatal on the first mismatch.

`ifndef REDMULE_TB_UTIL_SVH
`define REDMULE_TB_UTIL_SVH

// Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  logic [31:0] nxt;
  nxt = state >> 1;
  if (state[0]) begin
    nxt = nxt ^ 32'h8020_0003;
  end
  return nxt;
endfunction

// One beat of z = y + X*w, exact sum in 64 bits, then wrapped to 32 bits
function automatic redmule_pkg::z_vec_t model_beat(input redmule_pkg::z_vec_t acc,
                                                   input redmule_pkg::x_vec_t x,
                                                   input redmule_pkg::elem_t  w);
  redmule_pkg::z_vec_t res;
  longint              sum;
  for (int i = 0; i < redmule_pkg::ARRAY_WIDTH; i++) begin
    sum = longint'($signed(acc[i])) + longint'($signed(x[i])) * longint'($signed(w));
    // Low 32 bits of the exact sum
    res[i] = redmule_pkg::acc_t'(sum);
  end
  return res;
endfunction

task automatic check_z(input redmule_pkg::z_vec_t got, input redmule_pkg::z_vec_t exp,
                       input string what);
  if (got !== exp) begin
    $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    $display("Test failures found");
    $fatal(1, "Z mismatch");
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("ERR %0t: %s is %b expected %b", $time, what, got, exp);
    $display("Test failures found");
    $fatal(1, "status mismatch");
  end
endtask

`endif

// File: tb/redmule_tb.sv
// Testbench for the reduced MAC accelerator.
// All jobs, beats and gaps are generated up front from one LFSR seed.
// Inputs change 1 time unit after the rising edge, outputs are sampled at the falling edge.
// Only z_ready_i keeps drawing random bits while the jobs run.

`default_nettype none

module redmule_tb;

  localparam int NUM_JOBS      = 40;
  localparam int MAX_LEN       = 12;
  localparam int MAX_BEATS     = NUM_JOBS * MAX_LEN;
  localparam int BEAT_TIMEOUT  = 2000;
  localparam int START_TIMEOUT = 2000;
  localparam int END_TIMEOUT   = 50000;

  logic                clk_i;
  logic                reset_i;
  logic                start_i;
  redmule_pkg::len_t   job_len_i;
  redmule_pkg::z_vec_t bias_i;
  logic                x_valid_i;
  redmule_pkg::x_vec_t x_data_i;
  logic                x_ready_o;
  logic                w_valid_i;
  redmule_pkg::elem_t  w_data_i;
  logic                w_ready_o;
  logic                z_valid_o;
  redmule_pkg::z_vec_t z_data_o;
  logic                z_ready_i;
  logic                busy_o;
  logic                evt_o;
  logic                fault_o;

  logic [31:0]         lfsr_q = 32'h37ed_cbcb;

  // Generated jobs and their expected results
  redmule_pkg::len_t   job_len  [NUM_JOBS];
  redmule_pkg::z_vec_t job_bias [NUM_JOBS];
  redmule_pkg::z_vec_t job_exp  [NUM_JOBS];
  logic                spurious [NUM_JOBS];
  redmule_pkg::x_vec_t x_beats  [MAX_BEATS];
  redmule_pkg::elem_t  w_beats  [MAX_BEATS];
  int                  x_gap    [MAX_BEATS];
  int                  w_gap    [MAX_BEATS];
  int                  total_beats = 0;

  // Monitor state
  logic                monitor_on = 1'b0;
  logic                prev_stall = 1'b0;
  logic                prev_xfer  = 1'b0;
  redmule_pkg::z_vec_t prev_z;
  int                  results = 0;
  int                  starts  = 0;

  `include "redmule_tb_util.svh"

  redmule_top DUT (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .start_i   ( start_i   ),
    .job_len_i ( job_len_i ),
    .bias_i    ( bias_i    ),
    .x_valid_i ( x_valid_i ),
    .x_data_i  ( x_data_i  ),
    .x_ready_o ( x_ready_o ),
    .w_valid_i ( w_valid_i ),
    .w_data_i  ( w_data_i  ),
    .w_ready_o ( w_ready_o ),
    .z_valid_o ( z_valid_o ),
    .z_data_o  ( z_data_o  ),
    .z_ready_i ( z_ready_i ),
    .busy_o    ( busy_o    ),
    .evt_o     ( evt_o     ),
    .fault_o   ( fault_o   )
  );

  always begin
    clk_i = 1'b0;
    #5;
    clk_i = 1'b1;
    #5;
  end

  // One LFSR step per bit taken, first bit ends up as the MSB
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Test failures found");
    $fatal(1, "timeout");
  endtask

  task automatic drive_x_stream();
    int cnt;
    for (int i = 0; i < total_beats; i++) begin
      x_valid_i = 1'b0;
      repeat (x_gap[i]) begin
        @(posedge clk_i);
        #1;
      end
      x_valid_i = 1'b1;
      x_data_i  = x_beats[i];
      cnt = 0;
      @(negedge clk_i);
      while (!x_ready_o) begin
        cnt++;
        if (cnt > BEAT_TIMEOUT) report_timeout("x_ready_o");
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
    end
    x_valid_i = 1'b0;
  endtask

  task automatic feed_w_stream();
    int cnt;
    for (int i = 0; i < total_beats; i++) begin
      w_valid_i = 1'b0;
      repeat (w_gap[i]) begin
        @(posedge clk_i);
        #1;
      end
      w_valid_i = 1'b1;
      w_data_i  = w_beats[i];
      cnt = 0;
      @(negedge clk_i);
      while (!w_ready_o) begin
        cnt++;
        if (cnt > BEAT_TIMEOUT) report_timeout("w_ready_o");
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
    end
    w_valid_i = 1'b0;
  endtask

  // Starts each job once idle, sometimes followed by a start that must be ignored
  task automatic launch_jobs();
    int cnt;
    for (int j = 0; j < NUM_JOBS; j++) begin
      cnt = 0;
      @(negedge clk_i);
      while (busy_o) begin
        cnt++;
        if (cnt > START_TIMEOUT) report_timeout("busy_o to fall");
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
      start_i   = 1'b1;
      job_len_i = job_len[j];
      bias_i    = job_bias[j];
      @(posedge clk_i);
      #1;
      start_i = 1'b0;
      if (spurious[j]) begin
        start_i   = 1'b1;
        job_len_i = 8'd200;
        bias_i    = ~job_bias[j];
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
      end
    end
  endtask

  // Checks evaluated once per cycle, halfway between rising edges
  always @(negedge clk_i) begin
    if (monitor_on) begin
      check_bit(fault_o, 1'b0, "fault_o");
      if (prev_xfer) check_bit(busy_o, 1'b0, "busy_o after Z transfer");
      if (prev_stall) begin
        check_bit(z_valid_o, 1'b1, "z_valid_o under back-pressure");
        check_z(z_data_o, prev_z, "z_data_o under back-pressure");
      end
      check_bit(evt_o, z_valid_o & z_ready_i, "evt_o");
      if (start_i && !busy_o) starts++;
      if (z_valid_o && z_ready_i) begin
        if (results >= NUM_JOBS) begin
          $display("Extra Z result at %0t beyond %0d jobs", $time, NUM_JOBS);
          $display("Test failures found");
          $fatal(1, "extra result");
        end else begin
          check_z(z_data_o, job_exp[results], $sformatf("Z of job %0d", results));
          results++;
        end
      end
      prev_stall = z_valid_o & ~z_ready_i;
      prev_xfer  = z_valid_o & z_ready_i;
      prev_z     = z_data_o;
    end
  end

  initial begin
    redmule_pkg::z_vec_t acc;
    int                  cycles;
    reset_i   = 1'b1;
    start_i   = 1'b0;
    job_len_i = '0;
    bias_i    = '0;
    x_valid_i = 1'b0;
    x_data_i  = '0;
    w_valid_i = 1'b0;
    w_data_i  = '0;
    z_ready_i = 1'b0;

    for (int j = 0; j < NUM_JOBS; j++) begin
      job_len[j] = redmule_pkg::len_t'(rand_bits(4) % MAX_LEN + 1);
      for (int l = 0; l < redmule_pkg::ARRAY_WIDTH; l++) begin
        job_bias[j][l] = redmule_pkg::acc_t'(rand_bits(32));
      end
      spurious[j] = rand_bits(1) != 32'd0;
      acc = job_bias[j];
      for (int b = 0; b < int'(job_len[j]); b++) begin
        for (int l = 0; l < redmule_pkg::ARRAY_WIDTH; l++) begin
          x_beats[total_beats][l] = redmule_pkg::elem_t'(rand_bits(16));
        end
        w_beats[total_beats] = redmule_pkg::elem_t'(rand_bits(16));
        x_gap[total_beats]   = int'(rand_bits(2));
        w_gap[total_beats]   = int'(rand_bits(2));
        acc = model_beat(acc, x_beats[total_beats], w_beats[total_beats]);
        total_beats++;
      end
      job_exp[j] = acc;
    end

    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_bit(busy_o, 1'b0, "busy_o after reset");
    check_bit(z_valid_o, 1'b0, "z_valid_o after reset");
    check_bit(evt_o, 1'b0, "evt_o after reset");
    check_bit(fault_o, 1'b0, "fault_o after reset");
    check_bit(x_ready_o, 1'b1, "x_ready_o after reset");
    check_bit(w_ready_o, 1'b1, "w_ready_o after reset");
    monitor_on = 1'b1;

    @(posedge clk_i);
    #1;
    fork
      drive_x_stream();
      feed_w_stream();
      launch_jobs();
      forever begin
        // Ready three cycles out of four on average
        z_ready_i = rand_bits(2) != 32'd0;
        @(posedge clk_i);
        #1;
      end
    join_none

    cycles = 0;
    while (results < NUM_JOBS) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > END_TIMEOUT) report_timeout("all Z results");
    end
    repeat (4) @(negedge clk_i);

    if (starts == NUM_JOBS && results == NUM_JOBS) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Accepted starts %0d and results %0d differ from %0d jobs",
               starts, results, NUM_JOBS);
      $display("Test failures found");
      $fatal(1, "start and result counts differ");
    end
  end

endmodule

`default_nettype wire

// File: verilog/redmule_ctrl_dmr.sv
// Dual modular scheduler with an output comparator.
// Both replicas see the same inputs, replica 0 alone drives ctrl_o.
// A mismatch raises fault_o one cycle later and it stays set until reset.
// Detection only, there is no recovery path.

`default_nettype none

module redmule_ctrl_dmr (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     start_i,
  input  redmule_pkg::len_t        job_len_i,
  input  logic                     x_avail_i,
  input  logic                     w_avail_i,
  input  logic                     z_ready_i,
  output redmule_pkg::sched_ctrl_t ctrl_o,
  output logic                     fault_o
);

  redmule_pkg::sched_ctrl_t [1:0] rep_ctrl;
  logic                           mismatch;
  logic                           fault_q;

  for (genvar r = 0; r < 2; r++) begin : gen_replica
    redmule_scheduler i_scheduler (
      .clk_i     ( clk_i       ),
      .reset_i   ( reset_i     ),
      .start_i   ( start_i     ),
      .job_len_i ( job_len_i   ),
      .x_avail_i ( x_avail_i   ),
      .w_avail_i ( w_avail_i   ),
      .z_ready_i ( z_ready_i   ),
      .ctrl_o    ( rep_ctrl[r] )
    );
  end

  // Whole struct is voted, every field counts
  assign mismatch = rep_ctrl[0] != rep_ctrl[1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fault_q <= 1'b0;
    end else if (mismatch) begin
      fault_q <= 1'b1;
    end
  end

  assign ctrl_o  = rep_ctrl[0];
  assign fault_o = fault_q;

  // Replicas must agree in every cycle of normal operation
  assert property (@(posedge clk_i) disable iff (reset_i)
    rep_ctrl[0] == rep_ctrl[1])
    else $error("scheduler replicas disagree");

endmodule

`default_nettype wire

// File: verilog/redmule_engine.sv
// Integer MAC array, one lane per X element, all lanes share the W element.
// Stage 1 registers the products on pop, stage 2 adds them to the accumulators.
// load_bias and a product update never coincide, the scheduler keeps them apart.
// z_o holds the last stored result until the next store.

`default_nettype none

module redmule_engine (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  redmule_pkg::sched_ctrl_t ctrl_i,
  input  redmule_pkg::z_vec_t      bias_i,
  input  redmule_pkg::x_vec_t      x_i,
  input  redmule_pkg::elem_t       w_i,
  output redmule_pkg::z_vec_t      z_o
);

  redmule_pkg::z_vec_t prod_q;
  redmule_pkg::z_vec_t acc_q;
  redmule_pkg::z_vec_t z_q;
  logic                prod_valid_q;

  // Marks a product register holding a fresh pair
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prod_valid_q <= 1'b0;
    end else begin
      prod_valid_q <= ctrl_i.pop;
    end
  end

  // Product stage
  // 16x16 signed fits in 32 bits, so the product itself never wraps
  always_ff @(posedge clk_i) begin
    if (ctrl_i.pop) begin
      for (int i = 0; i < redmule_pkg::ARRAY_WIDTH; i++) begin
        prod_q[i] <= redmule_pkg::acc_t'($signed(x_i[i])) *
                     redmule_pkg::acc_t'($signed(w_i));
      end
    end
  end

  // Accumulator stage, sums wrap modulo 2^32
  always_ff @(posedge clk_i) begin
    if (ctrl_i.load_bias) begin
      acc_q <= bias_i;
    end else if (prod_valid_q) begin
      for (int i = 0; i < redmule_pkg::ARRAY_WIDTH; i++) begin
        acc_q[i] <= acc_q[i] + prod_q[i];
      end
    end
  end

  // Z holding register
  always_ff @(posedge clk_i) begin
    if (ctrl_i.store) begin
      z_q <= acc_q;
    end
  end

  assign z_o = z_q;

  // Store must only see a drained pipeline
  assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_i.store |-> !prod_valid_q && !ctrl_i.pop)
    else $error("store while products are still in flight");

  // Bias load must not overwrite a product still in flight
  assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_i.load_bias |-> !prod_valid_q)
    else $error("bias load during an active job");

endmodule

`default_nettype wire

// File: verilog/redmule_pkg.sv
// Shared widths, types and control encoding for the reduced MAC accelerator.
// X elements and W are signed 16 bit, accumulators and Z lanes are signed 32 bit.
// Sums wrap on overflow, so no saturation logic exists anywhere downstream.
// FIFO_DEPTH must stay a power of two because the FIFO pointers wrap naturally.

`default_nettype none

package redmule_pkg;

  // Number of MAC lanes, equal to elements per X beat and lanes per Z result
  localparam int unsigned ARRAY_WIDTH = 4;

  localparam int unsigned ELEM_W = 16;
  localparam int unsigned ACC_W  = 32;
  localparam int unsigned LEN_W  = 8;

  // Entries per input FIFO
  localparam int unsigned FIFO_DEPTH = 4;

  // Cycles from a pop to the accumulator update
  localparam int unsigned PIPE_STAGES = 2;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic        [LEN_W-1:0]  len_t;

  // One X column, lane 0 in the low bits
  typedef elem_t [ARRAY_WIDTH-1:0] x_vec_t;

  // Bias vector and result vector share this layout
  typedef acc_t [ARRAY_WIDTH-1:0] z_vec_t;

  typedef enum logic [2:0] {
    IDLE,
    RUN,
    DRAIN,
    STORE,
    OUTPUT
  } sched_state_e;

  // Scheduler control towards the FIFOs, the engine and the status pins
  typedef struct packed {
    logic pop;        // take one X/W pair this cycle
    logic load_bias;  // accumulators take the bias on this edge
    logic store;      // accumulators go to the Z register
    logic z_valid;
    logic busy;
    logic done;       // one cycle, on the Z transfer
  } sched_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/redmule_scheduler.sv
// Job FSM for one matrix-vector job of job_len_i beats.
// start_i is only looked at in IDLE, a start in any other state is ignored.
// Pops happen in RUN whenever both FIFOs hold data, one pair per cycle.
// DRAIN waits PIPE_STAGES cycles so the last product reaches the accumulators.

`default_nettype none

module redmule_scheduler (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     start_i,
  input  redmule_pkg::len_t        job_len_i,
  input  logic                     x_avail_i,
  input  logic                     w_avail_i,
  input  logic                     z_ready_i,
  output redmule_pkg::sched_ctrl_t ctrl_o
);

  redmule_pkg::sched_state_e                     state_q;
  redmule_pkg::sched_state_e                     state_d;
  redmule_pkg::len_t                             beats_q;
  logic [$clog2(redmule_pkg::PIPE_STAGES+1)-1:0] drain_q;
  logic                                          pop_en;
  logic                                          start_ok;

  assign start_ok = (state_q == redmule_pkg::IDLE) & start_i;
  assign pop_en   = (state_q == redmule_pkg::RUN) & x_avail_i & w_avail_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      redmule_pkg::IDLE: begin
        if (start_i) begin
          state_d = redmule_pkg::RUN;
        end
      end
      redmule_pkg::RUN: begin
        // Last pair of the job leaves the FIFOs
        if (pop_en && beats_q == redmule_pkg::len_t'(1)) begin
          state_d = redmule_pkg::DRAIN;
        end
      end
      redmule_pkg::DRAIN: begin
        if (drain_q == '0) begin
          state_d = redmule_pkg::STORE;
        end
      end
      redmule_pkg::STORE: begin
        state_d = redmule_pkg::OUTPUT;
      end
      redmule_pkg::OUTPUT: begin
        if (z_ready_i) begin
          state_d = redmule_pkg::IDLE;
        end
      end
      default: begin
        state_d = redmule_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= redmule_pkg::IDLE;
      beats_q <= '0;
      drain_q <= '0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        beats_q <= job_len_i;
      end else if (pop_en) begin
        beats_q <= beats_q - redmule_pkg::len_t'(1);
      end
      // Drain count is armed during RUN and counts down in DRAIN
      if (state_q == redmule_pkg::RUN) begin
        drain_q <= $bits(drain_q)'(redmule_pkg::PIPE_STAGES - 1);
      end else if (state_q == redmule_pkg::DRAIN) begin
        drain_q <= drain_q - 1'b1;
      end
    end
  end

  always_comb begin
    ctrl_o           = '0;
    ctrl_o.pop       = pop_en;
    ctrl_o.load_bias = start_ok;
    ctrl_o.store     = state_q == redmule_pkg::STORE;
    ctrl_o.z_valid   = state_q == redmule_pkg::OUTPUT;
    ctrl_o.busy      = state_q != redmule_pkg::IDLE;
    ctrl_o.done      = (state_q == redmule_pkg::OUTPUT) & z_ready_i;
  end

  // A zero length job would stay in RUN forever
  assert property (@(posedge clk_i) disable iff (reset_i)
    start_ok |-> job_len_i != '0)
    else $error("job started with zero length");

  // No pop beyond the job length or outside RUN
  assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_o.pop |-> state_q == redmule_pkg::RUN && beats_q != '0)
    else $error("pop outside of an active RUN phase");

endmodule

`default_nettype wire

// File: verilog/redmule_stream_fifo.sv
// Valid/ready FIFO for one input stream, read side is a pop strobe.
// DEPTH must be a power of two of at least 2.
// A push is taken only while not full, even if a pop happens in the same cycle.
// The head entry is visible one cycle after it was pushed.

`default_nettype none

module redmule_stream_fifo #(
  parameter int unsigned DATA_W = 16,
  parameter int unsigned DEPTH  = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              push_valid_i,
  input  logic [DATA_W-1:0] push_data_i,
  output logic              push_ready_o,
  input  logic              pop_i,
  output logic [DATA_W-1:0] pop_data_o,
  output logic              not_empty_o
);

  logic [DATA_W-1:0]          mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       push_fire;

  assign push_ready_o = count_q != $bits(count_q)'(DEPTH);
  assign not_empty_o  = count_q != '0;
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_data_o   = mem_q[rd_ptr_q];

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_fire && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (!push_fire && pop_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // The consumer side only pops what is already stored
  assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> not_empty_o)
    else $error("FIFO pop while empty");

  // A stalled producer keeps its beat until it is taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_data_i))
    else $error("push data dropped or changed while stalled");

endmodule

`default_nettype wire

// File: verilog/redmule_top.sv
// Top level of the reduced MAC accelerator, computes z = y + X*w per job.
// X and W beats are paired by order, one X column with one w element.
// start_i and bias_i are sampled together, and only while busy_o is low.
// evt_o pulses on the Z transfer, in the same edge that drops busy_o.

`default_nettype none

module redmule_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                start_i,
  input  redmule_pkg::len_t   job_len_i,
  input  redmule_pkg::z_vec_t bias_i,
  input  logic                x_valid_i,
  input  redmule_pkg::x_vec_t x_data_i,
  output logic                x_ready_o,
  input  logic                w_valid_i,
  input  redmule_pkg::elem_t  w_data_i,
  output logic                w_ready_o,
  output logic                z_valid_o,
  output redmule_pkg::z_vec_t z_data_o,
  input  logic                z_ready_i,
  output logic                busy_o,
  output logic                evt_o,
  output logic                fault_o
);

  redmule_pkg::sched_ctrl_t ctrl;
  redmule_pkg::x_vec_t      x_head;
  redmule_pkg::elem_t       w_head;
  logic                     x_avail;
  logic                     w_avail;

  // X input buffer
  redmule_stream_fifo #(
    .DATA_W ( $bits(redmule_pkg::x_vec_t) ),
    .DEPTH  ( redmule_pkg::FIFO_DEPTH     )
  ) i_x_fifo (
    .clk_i        ( clk_i     ),
    .reset_i      ( reset_i   ),
    .push_valid_i ( x_valid_i ),
    .push_data_i  ( x_data_i  ),
    .push_ready_o ( x_ready_o ),
    .pop_i        ( ctrl.pop  ),
    .pop_data_o   ( x_head    ),
    .not_empty_o  ( x_avail   )
  );

  // W input buffer
  redmule_stream_fifo #(
    .DATA_W ( $bits(redmule_pkg::elem_t) ),
    .DEPTH  ( redmule_pkg::FIFO_DEPTH    )
  ) i_w_fifo (
    .clk_i        ( clk_i     ),
    .reset_i      ( reset_i   ),
    .push_valid_i ( w_valid_i ),
    .push_data_i  ( w_data_i  ),
    .push_ready_o ( w_ready_o ),
    .pop_i        ( ctrl.pop  ),
    .pop_data_o   ( w_head    ),
    .not_empty_o  ( w_avail   )
  );

  redmule_ctrl_dmr i_ctrl (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .start_i   ( start_i   ),
    .job_len_i ( job_len_i ),
    .x_avail_i ( x_avail   ),
    .w_avail_i ( w_avail   ),
    .z_ready_i ( z_ready_i ),
    .ctrl_o    ( ctrl      ),
    .fault_o   ( fault_o   )
  );

  redmule_engine i_engine (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .ctrl_i  ( ctrl     ),
    .bias_i  ( bias_i   ),
    .x_i     ( x_head   ),
    .w_i     ( w_head   ),
    .z_o     ( z_data_o )
  );

  // Status pins come straight from the voted control word
  assign z_valid_o = ctrl.z_valid;
  assign busy_o    = ctrl.busy;
  assign evt_o     = ctrl.done;

endmodule

`default_nettype wire
